/* rs_cfg_pkg.sv */
package rs_cfg_pkg;

    // number of station slots
    localparam int RS_DEPTH = 8;

    // enqueue ports, also the number of issue ports
    localparam int RS_PORTS = 2;

    // result buses that can wake up a waiting operand
    localparam int WB_PORTS = 3;

    // width of a slot index
    localparam int RS_IDX_W = 3;

endpackage

/* rs_uop_pkg.sv */
package rs_uop_pkg;

    // integer datapath width
    localparam int XLEN = 32;

    // physical register tag width
    localparam int PREG_W = 6;

    // functional unit class, carried through untouched
    localparam int FU_W = 3;

    // operands held per micro-op
    localparam int NUM_SRCS = 2;

    // one operand slot of a micro-op
    // while the ready bit is low the word holds the producer tag,
    // after wakeup the same word holds the operand value
    typedef union packed {
        logic [XLEN-1:0] data;
        struct packed {
            logic [XLEN-PREG_W-1:0] unused;
            logic [PREG_W-1:0]      tag;
        } tag_view;
    } src_word_u;

endpackage

/* rs_alloc.sv */
module rs_alloc (
    input  logic                              clk,
    input  logic                              i_reset,
    input  logic [rs_cfg_pkg::RS_PORTS-1:0]   i_enq_req,
    input  logic [rs_cfg_pkg::RS_DEPTH-1:0]   i_entry_vld,
    output logic [rs_cfg_pkg::RS_PORTS-1:0]   o_can_enq,
    output logic [rs_cfg_pkg::RS_DEPTH-1:0]   o_entry_wr,
    output logic [rs_cfg_pkg::RS_DEPTH-1:0]   o_entry_port
);
    import rs_cfg_pkg::*;

    logic [RS_DEPTH-1:0] free;
    logic [RS_IDX_W:0]   free_cnt;
    logic [RS_IDX_W-1:0] idx0;
    logic [RS_IDX_W-1:0] idx1;
    logic [RS_PORTS-1:0] enq_acc;

    assign free = ~i_entry_vld;

    // free slot count drives the per-port can-enqueue flags
    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            free_cnt = free_cnt + (RS_IDX_W + 1)'(free[i]);
        end
        for (int j = 0; j < RS_PORTS; j++) begin
            o_can_enq[j] = (free_cnt > (RS_IDX_W + 1)'(j));
        end
    end

    // port 0 takes the lowest free slot, port 1 the next one up
    always_comb begin
        idx0 = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (free[i]) begin
                idx0 = RS_IDX_W'(i);
            end
        end
        idx1 = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (free[i] && (RS_IDX_W'(i) != idx0)) begin
                idx1 = RS_IDX_W'(i);
            end
        end
    end

    // only requests that see can-enqueue are written
    assign enq_acc = i_enq_req & o_can_enq;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            o_entry_wr[i]   = (enq_acc[0] && (idx0 == RS_IDX_W'(i))) ||
                              (enq_acc[1] && (idx1 == RS_IDX_W'(i)));
            // entry mux select, high when port 1 owns the write
            o_entry_port[i] = enq_acc[1] && (idx1 == RS_IDX_W'(i));
        end
    end

    // requests are packed from port 0 upward by the rename stage
    a_enq_packed : assert property (
        @(posedge clk) disable iff (i_reset)
        i_enq_req[1] |-> i_enq_req[0]
    );

endmodule

/* rs_entry.sv */
module rs_entry (
    input  logic                               clk,
    input  logic                               i_reset,
    input  logic                               i_wr,
    input  logic [rs_uop_pkg::FU_W-1:0]        i_fu,
    input  logic [rs_uop_pkg::PREG_W-1:0]      i_dest,
    input  rs_uop_pkg::src_word_u              i_src0,
    input  rs_uop_pkg::src_word_u              i_src1,
    input  logic                               i_rdy0,
    input  logic                               i_rdy1,
    input  logic [rs_cfg_pkg::WB_PORTS-1:0]    i_wb_vld,
    input  logic [rs_uop_pkg::PREG_W-1:0]      i_wb_tag [rs_cfg_pkg::WB_PORTS],
    input  logic [rs_uop_pkg::XLEN-1:0]        i_wb_data [rs_cfg_pkg::WB_PORTS],
    input  logic                               i_clr,
    output logic                               o_vld,
    output logic                               o_rdy,
    output logic [rs_uop_pkg::FU_W-1:0]        o_fu,
    output logic [rs_uop_pkg::PREG_W-1:0]      o_dest,
    output rs_uop_pkg::src_word_u              o_src0,
    output rs_uop_pkg::src_word_u              o_src1
);
    import rs_cfg_pkg::*;
    import rs_uop_pkg::*;

    logic                vld_q;
    logic [FU_W-1:0]     fu_q;
    logic [PREG_W-1:0]   dest_q;
    src_word_u           src_q [NUM_SRCS];
    logic [NUM_SRCS-1:0] rdy_q;

    src_word_u           src_in [NUM_SRCS];
    logic [NUM_SRCS-1:0] rdy_in;
    src_word_u           src_cur [NUM_SRCS];
    logic [NUM_SRCS-1:0] rdy_cur;
    src_word_u           src_d [NUM_SRCS];
    logic [NUM_SRCS-1:0] wake;

    assign src_in[0] = i_src0;
    assign src_in[1] = i_src1;
    assign rdy_in    = {i_rdy1, i_rdy0};

    // tag compare runs on the incoming word during a write,
    // so a broadcast in the enqueue cycle is still caught
    always_comb begin
        for (int s = 0; s < NUM_SRCS; s++) begin
            src_cur[s] = i_wr ? src_in[s] : src_q[s];
            rdy_cur[s] = i_wr ? rdy_in[s] : rdy_q[s];
            src_d[s]   = src_cur[s];
            wake[s]    = 1'b0;
            for (int w = 0; w < WB_PORTS; w++) begin
                if (!rdy_cur[s] && i_wb_vld[w] &&
                    (i_wb_tag[w] == src_cur[s].tag_view.tag)) begin
                    wake[s]       = 1'b1;
                    src_d[s].data = i_wb_data[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            vld_q <= 1'b0;
        end else if (i_wr) begin
            vld_q <= 1'b1;
        end else if (i_clr) begin
            vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr) begin
            fu_q   <= i_fu;
            dest_q <= i_dest;
        end
        for (int s = 0; s < NUM_SRCS; s++) begin
            if (i_wr || (vld_q && wake[s])) begin
                src_q[s] <= src_d[s];
                rdy_q[s] <= rdy_cur[s] | wake[s];
            end
        end
    end

    assign o_vld  = vld_q;
    assign o_rdy  = vld_q && (&rdy_q);
    assign o_fu   = fu_q;
    assign o_dest = dest_q;
    assign o_src0 = src_q[0];
    assign o_src1 = src_q[1];

    // allocator only writes free slots and select only clears issued ones
    a_wr_clr_excl : assert property (
        @(posedge clk) disable iff (i_reset)
        !(i_wr && i_clr)
    );

endmodule

/* rs_select.sv */
module rs_select (
    input  logic                              clk,
    input  logic                              i_reset,
    input  logic [rs_cfg_pkg::RS_DEPTH-1:0]   i_entry_rdy,
    input  logic [rs_uop_pkg::FU_W-1:0]       i_entry_fu [rs_cfg_pkg::RS_DEPTH],
    input  logic [rs_uop_pkg::PREG_W-1:0]     i_entry_dest [rs_cfg_pkg::RS_DEPTH],
    input  rs_uop_pkg::src_word_u             i_entry_src0 [rs_cfg_pkg::RS_DEPTH],
    input  rs_uop_pkg::src_word_u             i_entry_src1 [rs_cfg_pkg::RS_DEPTH],
    input  logic [rs_cfg_pkg::RS_PORTS-1:0]   i_deq_req,
    output logic [rs_cfg_pkg::RS_PORTS-1:0]   o_can_deq,
    output logic [rs_uop_pkg::FU_W-1:0]       o_deq_fu [rs_cfg_pkg::RS_PORTS],
    output logic [rs_uop_pkg::PREG_W-1:0]     o_deq_dest [rs_cfg_pkg::RS_PORTS],
    output rs_uop_pkg::src_word_u             o_deq_src0 [rs_cfg_pkg::RS_PORTS],
    output rs_uop_pkg::src_word_u             o_deq_src1 [rs_cfg_pkg::RS_PORTS],
    output logic [rs_cfg_pkg::RS_DEPTH-1:0]   o_entry_clr
);
    import rs_cfg_pkg::*;

    logic [RS_PORTS-1:0] sel_vld_q;
    logic [RS_IDX_W-1:0] sel_idx_q [RS_PORTS];
    logic [RS_PORTS-1:0] deq_acc;
    logic [RS_DEPTH-1:0] cand;
    logic [RS_PORTS-1:0] pick_vld;
    logic [RS_IDX_W-1:0] pick_idx [RS_PORTS];

    assign o_can_deq = sel_vld_q;
    assign deq_acc   = i_deq_req & sel_vld_q;

    // clear strobes for the slots that leave at this edge
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            o_entry_clr[i] = 1'b0;
            for (int j = 0; j < RS_PORTS; j++) begin
                if (deq_acc[j] && (sel_idx_q[j] == RS_IDX_W'(i))) begin
                    o_entry_clr[i] = 1'b1;
                end
            end
        end
    end

    // a slot leaving now must not be picked again
    assign cand = i_entry_rdy & ~o_entry_clr;

    // positional priority, lowest index wins
    always_comb begin
        pick_vld[0] = 1'b0;
        pick_idx[0] = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (cand[i]) begin
                pick_vld[0] = 1'b1;
                pick_idx[0] = RS_IDX_W'(i);
            end
        end
        pick_vld[1] = 1'b0;
        pick_idx[1] = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (cand[i] && (RS_IDX_W'(i) != pick_idx[0])) begin
                pick_vld[1] = 1'b1;
                pick_idx[1] = RS_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sel_vld_q <= '0;
            for (int j = 0; j < RS_PORTS; j++) begin
                sel_idx_q[j] <= '0;
            end
        end else begin
            sel_vld_q <= pick_vld;
            for (int j = 0; j < RS_PORTS; j++) begin
                sel_idx_q[j] <= pick_idx[j];
            end
        end
    end

    // payload follows the registered choice
    always_comb begin
        for (int j = 0; j < RS_PORTS; j++) begin
            o_deq_fu[j]   = i_entry_fu[sel_idx_q[j]];
            o_deq_dest[j] = i_entry_dest[sel_idx_q[j]];
            o_deq_src0[j] = i_entry_src0[sel_idx_q[j]];
            o_deq_src1[j] = i_entry_src1[sel_idx_q[j]];
        end
    end

    // both issue ports never point at the same slot
    a_idx_distinct : assert property (
        @(posedge clk) disable iff (i_reset)
        (&sel_vld_q) |-> (sel_idx_q[0] != sel_idx_q[1])
    );

    // port 1 only carries work when port 0 does
    a_deq_packed : assert property (
        @(posedge clk) disable iff (i_reset)
        o_can_deq[1] |-> o_can_deq[0]
    );

endmodule

/* rs_top.sv */
module rs_top (
    input  logic                              clk,
    input  logic                              i_reset,
    input  logic [rs_cfg_pkg::RS_PORTS-1:0]   i_enq_req,
    input  logic [rs_uop_pkg::FU_W-1:0]       i_enq_fu [rs_cfg_pkg::RS_PORTS],
    input  logic [rs_uop_pkg::PREG_W-1:0]     i_enq_dest [rs_cfg_pkg::RS_PORTS],
    input  rs_uop_pkg::src_word_u             i_enq_src0 [rs_cfg_pkg::RS_PORTS],
    input  rs_uop_pkg::src_word_u             i_enq_src1 [rs_cfg_pkg::RS_PORTS],
    input  logic [rs_cfg_pkg::RS_PORTS-1:0]   i_enq_rdy0,
    input  logic [rs_cfg_pkg::RS_PORTS-1:0]   i_enq_rdy1,
    output logic [rs_cfg_pkg::RS_PORTS-1:0]   o_can_enq,
    input  logic [rs_cfg_pkg::WB_PORTS-1:0]   i_wb_vld,
    input  logic [rs_uop_pkg::PREG_W-1:0]     i_wb_tag [rs_cfg_pkg::WB_PORTS],
    input  logic [rs_uop_pkg::XLEN-1:0]       i_wb_data [rs_cfg_pkg::WB_PORTS],
    output logic [rs_cfg_pkg::RS_PORTS-1:0]   o_can_deq,
    output logic [rs_uop_pkg::FU_W-1:0]       o_deq_fu [rs_cfg_pkg::RS_PORTS],
    output logic [rs_uop_pkg::PREG_W-1:0]     o_deq_dest [rs_cfg_pkg::RS_PORTS],
    output rs_uop_pkg::src_word_u             o_deq_src0 [rs_cfg_pkg::RS_PORTS],
    output rs_uop_pkg::src_word_u             o_deq_src1 [rs_cfg_pkg::RS_PORTS],
    input  logic [rs_cfg_pkg::RS_PORTS-1:0]   i_deq_req
);
    import rs_cfg_pkg::*;
    import rs_uop_pkg::*;

    logic [RS_DEPTH-1:0] entry_wr;
    logic [RS_DEPTH-1:0] entry_port;
    logic [RS_DEPTH-1:0] entry_vld;
    logic [RS_DEPTH-1:0] entry_rdy;
    logic [RS_DEPTH-1:0] entry_clr;
    logic [FU_W-1:0]     entry_fu [RS_DEPTH];
    logic [PREG_W-1:0]   entry_dest [RS_DEPTH];
    src_word_u           entry_src0 [RS_DEPTH];
    src_word_u           entry_src1 [RS_DEPTH];

    rs_alloc u_alloc (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_enq_req    (i_enq_req),
        .i_entry_vld  (entry_vld),
        .o_can_enq    (o_can_enq),
        .o_entry_wr   (entry_wr),
        .o_entry_port (entry_port)
    );

    // each slot picks its enqueue fields from the port the allocator names
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        rs_entry u_entry (
            .clk       (clk),
            .i_reset   (i_reset),
            .i_wr      (entry_wr[i]),
            .i_fu      (i_enq_fu[entry_port[i]]),
            .i_dest    (i_enq_dest[entry_port[i]]),
            .i_src0    (i_enq_src0[entry_port[i]]),
            .i_src1    (i_enq_src1[entry_port[i]]),
            .i_rdy0    (i_enq_rdy0[entry_port[i]]),
            .i_rdy1    (i_enq_rdy1[entry_port[i]]),
            .i_wb_vld  (i_wb_vld),
            .i_wb_tag  (i_wb_tag),
            .i_wb_data (i_wb_data),
            .i_clr     (entry_clr[i]),
            .o_vld     (entry_vld[i]),
            .o_rdy     (entry_rdy[i]),
            .o_fu      (entry_fu[i]),
            .o_dest    (entry_dest[i]),
            .o_src0    (entry_src0[i]),
            .o_src1    (entry_src1[i])
        );
    end

    rs_select u_select (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_entry_rdy  (entry_rdy),
        .i_entry_fu   (entry_fu),
        .i_entry_dest (entry_dest),
        .i_entry_src0 (entry_src0),
        .i_entry_src1 (entry_src1),
        .i_deq_req    (i_deq_req),
        .o_can_deq    (o_can_deq),
        .o_deq_fu     (o_deq_fu),
        .o_deq_dest   (o_deq_dest),
        .o_deq_src0   (o_deq_src0),
        .o_deq_src1   (o_deq_src1),
        .o_entry_clr  (entry_clr)
    );

endmodule

/* tb_rs.sv */
module tb_rs;
    import rs_cfg_pkg::*;
    import rs_uop_pkg::*;

    // column layout of one pattern line, see the header of rs_patterns.txt
    localparam int NF        = 27;
    localparam int MAX_STEPS = 64;
    localparam int C_RDY     = 10;
    localparam int C_WB      = 11;
    localparam int C_DEQ     = 18;
    localparam int C_EXP     = 19;
    localparam int C_PAY     = 21;

    logic                clk;
    logic                i_reset;
    logic [RS_PORTS-1:0] i_enq_req;
    logic [FU_W-1:0]     i_enq_fu [RS_PORTS];
    logic [PREG_W-1:0]   i_enq_dest [RS_PORTS];
    src_word_u           i_enq_src0 [RS_PORTS];
    src_word_u           i_enq_src1 [RS_PORTS];
    logic [RS_PORTS-1:0] i_enq_rdy0;
    logic [RS_PORTS-1:0] i_enq_rdy1;
    logic [RS_PORTS-1:0] o_can_enq;
    logic [WB_PORTS-1:0] i_wb_vld;
    logic [PREG_W-1:0]   i_wb_tag [WB_PORTS];
    logic [XLEN-1:0]     i_wb_data [WB_PORTS];
    logic [RS_PORTS-1:0] o_can_deq;
    logic [FU_W-1:0]     o_deq_fu [RS_PORTS];
    logic [PREG_W-1:0]   o_deq_dest [RS_PORTS];
    src_word_u           o_deq_src0 [RS_PORTS];
    src_word_u           o_deq_src1 [RS_PORTS];
    logic [RS_PORTS-1:0] i_deq_req;

    logic [31:0] pat [MAX_STEPS*NF];
    int          n_steps;
    int          cycle_limit;
    int          cycles = 0;
    int          n_checks;
    int          n_errors;
    int          n_groups;
    int          grp_checks;
    int          grp_errors;

    // fu class of each accepted micro-op, looked up by its destination tag
    logic [FU_W-1:0] fu_by_dest [1<<PREG_W];

    rs_top uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // run length is bounded by the number of pattern lines
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: simulation did not finish");
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic note_fail(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        n_errors++;
        grp_errors++;
    endtask

    task automatic drive_idle();
        i_enq_req = '0;
        i_enq_rdy0 = '0;
        i_enq_rdy1 = '0;
        i_wb_vld = '0;
        i_deq_req = '0;
        for (int j = 0; j < RS_PORTS; j++) begin
            i_enq_fu[j] = '0;
            i_enq_dest[j] = '0;
            i_enq_src0[j] = '0;
            i_enq_src1[j] = '0;
        end
        for (int w = 0; w < WB_PORTS; w++) begin
            i_wb_tag[w] = '0;
            i_wb_data[w] = '0;
        end
    endtask

    task automatic apply_step(input int b);
        logic [RS_PORTS-1:0] acc;
        acc = pat[b+1][RS_PORTS-1:0] & pat[b+C_EXP][RS_PORTS-1:0];
        i_enq_req = pat[b+1][RS_PORTS-1:0];
        for (int j = 0; j < RS_PORTS; j++) begin
            i_enq_fu[j] = pat[b+2+4*j][FU_W-1:0];
            i_enq_dest[j] = pat[b+3+4*j][PREG_W-1:0];
            i_enq_src0[j].data = pat[b+4+4*j];
            i_enq_src1[j].data = pat[b+5+4*j];
            // two ready bits per port, src0 in the lower one
            i_enq_rdy0[j] = pat[b+C_RDY][2*j];
            i_enq_rdy1[j] = pat[b+C_RDY][2*j+1];
            if (acc[j]) begin
                fu_by_dest[pat[b+3+4*j][PREG_W-1:0]] = pat[b+2+4*j][FU_W-1:0];
            end
        end
        i_wb_vld = pat[b+C_WB][WB_PORTS-1:0];
        for (int w = 0; w < WB_PORTS; w++) begin
            i_wb_tag[w] = pat[b+C_WB+1+2*w][PREG_W-1:0];
            i_wb_data[w] = pat[b+C_WB+2+2*w];
        end
        i_deq_req = pat[b+C_DEQ][RS_PORTS-1:0];
    endtask

    task automatic check_step(input int b);
        logic [RS_PORTS-1:0] exp_enq;
        logic [RS_PORTS-1:0] exp_deq;
        logic [FU_W-1:0]     exp_fu;
        int                  p;
        exp_enq = pat[b+C_EXP][RS_PORTS-1:0];
        exp_deq = pat[b+C_EXP+1][RS_PORTS-1:0];
        n_checks += 2;
        grp_checks += 2;
        if (o_can_enq !== exp_enq) begin
            note_fail($sformatf("o_can_enq is %b, expected %b", o_can_enq, exp_enq));
        end
        if (o_can_deq !== exp_deq) begin
            note_fail($sformatf("o_can_deq is %b, expected %b", o_can_deq, exp_deq));
        end
        // payload is only defined on ports that offer a micro-op
        for (int j = 0; j < RS_PORTS; j++) begin
            p = b + C_PAY + 3 * j;
            if (exp_deq[j]) begin
                n_checks += 4;
                grp_checks += 4;
                exp_fu = fu_by_dest[pat[p][PREG_W-1:0]];
                if (o_deq_fu[j] !== exp_fu) begin
                    note_fail($sformatf("port %0d fu is %h, expected %h",
                                        j, o_deq_fu[j], exp_fu));
                end
                if (o_deq_dest[j] !== pat[p][PREG_W-1:0]) begin
                    note_fail($sformatf("port %0d dest is %h, expected %h",
                                        j, o_deq_dest[j], pat[p][PREG_W-1:0]));
                end
                if (o_deq_src0[j].data !== pat[p+1]) begin
                    note_fail($sformatf("port %0d src0 is %h, expected %h",
                                        j, o_deq_src0[j].data, pat[p+1]));
                end
                if (o_deq_src1[j].data !== pat[p+2]) begin
                    note_fail($sformatf("port %0d src1 is %h, expected %h",
                                        j, o_deq_src1[j].data, pat[p+2]));
                end
            end
        end
    endtask

    task automatic report_group(input int g);
        $display("group %0d: %0d checks, %0d errors", g, grp_checks, grp_errors);
        n_groups++;
        grp_checks = 0;
        grp_errors = 0;
    endtask

    initial begin
        int b;
        int cur_grp;
        i_reset = 1'b1;
        drive_idle();
        n_checks = 0;
        n_errors = 0;
        n_groups = 0;
        grp_checks = 0;
        grp_errors = 0;
        $readmemh("rs_patterns.txt", pat);
        // a line whose group is ff ends the table
        n_steps = 0;
        while ((n_steps < MAX_STEPS) && (pat[n_steps*NF] != 32'hff)) begin
            n_steps++;
        end
        cycle_limit = n_steps + 50;
        repeat (10) @(negedge clk);
        i_reset = 1'b0;
        cur_grp = pat[0];
        for (int k = 0; k < n_steps; k++) begin
            b = k * NF;
            if (k > 0) begin
                @(negedge clk);
            end
            if (pat[b] != cur_grp) begin
                report_group(cur_grp);
                cur_grp = pat[b];
            end
            check_step(b);
            apply_step(b);
        end
        report_group(cur_grp);
        $display("done: %0d groups, %0d checks, %0d errors", n_groups, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* rs_patterns.txt */
// grp req | port0 fu dest src0 src1 | port1 fu dest src0 src1 | rdy (p0s0 p0s1 p1s0 p1s1 from bit 0)
// wb vld, then tag and data for ports 0 1 2 | deq | expected can_enq can_deq
// expected dest src0 src1 for deq port 0, then for deq port 1 | group ff ends the table
01 01 01 0a 11 12 00 00 00 00 03 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01 03 01 0a 11 12 00 00 00
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
02 01 02 0b 05 22 00 00 00 00 02 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
02 00 00 00 00 00 00 00 00 00 00 01 06 99 00 00 00 00 00 03 00 00 00 00 00 00 00
02 00 00 00 00 00 00 00 00 00 00 02 00 00 05 c5 00 00 00 03 00 00 00 00 00 00 00
02 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
02 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01 03 01 0b c5 22 00 00 00
02 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
03 03 03 0c 31 07 04 0d 08 32 09 05 08 e8 00 00 07 d7 00 03 00 00 00 00 00 00 00
03 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
03 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 03 03 0c 31 d7 0d e8 32
03 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
04 03 05 20 40 10 05 21 41 10 05 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
04 03 05 22 42 10 05 23 43 10 05 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
04 03 05 24 44 10 05 25 45 10 05 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
04 01 05 26 46 10 00 00 00 00 01 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
04 03 05 27 47 10 05 2f 4f 10 05 00 00 00 00 00 00 00 00 01 00 00 00 00 00 00 00
04 01 05 2e 4e 10 00 00 00 00 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
04 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
05 00 00 00 00 00 00 00 00 00 00 01 10 77 00 00 00 00 00 00 00 00 00 00 00 00 00
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 20 40 77 21 41 77
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 20 40 77 21 41 77
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01 00 03 20 40 77 21 41 77
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 01 03 21 41 77 22 42 77
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 03 03 23 43 77 24 44 77
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 03 03 23 43 77 25 45 77
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 03 03 26 46 77 27 47 77
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00
ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

/* flist.f */
rs_cfg_pkg.sv
rs_uop_pkg.sv
rs_alloc.sv
rs_entry.sv
rs_select.sv
rs_top.sv
tb_rs.sv

/* run_sim.sh */
#!/bin/bash
# build the reservation station testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_rs -f flist.f -o Vtb_rs || exit 1
out=$(./obj_dir/Vtb_rs)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && exit 0 || exit 1
